/* run_sim.sh */
#!/bin/sh
# Compile the testbench and RTL with Verilator, run, and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lora_periph -Mdir obj_dir -f sim.f

./obj_dir/Vtb_lora_periph | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* sim.f */
+incdir+source
source/soc_pkg.sv
source/reset_hold.sv
source/time_base.sv
source/async_inputs.sv
source/mmio_regs.sv
source/lora_periph_top.sv
verif/tb_lora_periph.sv

/* source/async_inputs.sv */
// Synchronizers for the asynchronous input pins
// PPS high time must be at least 2 clk cycles to be seen
// Count goes up 3 cycles after the PPS edge; DIO1 lags its pin by 2 cycles

`timescale 1ns/1ns

module async_inputs
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_reg_n,    // Peripheral reset
    input  logic       i_pps_pin,    // 1PPS from the GNSS module
    input  logic       i_dio1_pin,   // Radio DIO1 interrupt line
    output pps_count_t o_pps_count,
    output logic       o_dio1_irq
);

    logic [1:0] pps_sync;   // [1] is the clean level
    logic       pps_prev;   // Last clean level for edge detect
    logic       pps_rise;
    logic [1:0] dio1_sync;

    // ==============================
    // Two-flop synchronizers
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            pps_sync  <= 2'b00;
            pps_prev  <= 1'b0;
            dio1_sync <= 2'b00;
        end else begin
            pps_sync  <= {pps_sync[0], i_pps_pin};
            pps_prev  <= pps_sync[1];
            dio1_sync <= {dio1_sync[0], i_dio1_pin};
        end
    end

    assign pps_rise = pps_sync[1] && !pps_prev;

    // PPS edge counter, wraps at 16 bits
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            o_pps_count <= '0;
        end else if (pps_rise) begin
            o_pps_count <= o_pps_count + 1'b1;
        end
    end

    assign o_dio1_irq = dio1_sync[1];  // Level, cleared at the radio over SPI

endmodule

/* source/lora_periph_top.sv */
// Peripheral subsystem of the LoRa node
// i_ui_in[0] is radio DIO1, i_ui_in[4] is 1PPS; other input bits are plain GPIO
// Soft reset holds all peripherals, but not the reset block itself, for 32 cycles

`timescale 1ns/1ns

module lora_periph_top
    import soc_pkg::*;
(
    input  logic   clk,
    input  logic   rst_reg_n,    // External sync reset, active low
    input  addr_t  i_addr,
    input  wstrb_t i_write_n,
    input  data_t  i_wdata,
    input  pins_t  i_ui_in,
    output data_t  o_rdata,
    output pins_t  o_uo_out,
    output logic   o_timer_irq,
    output logic   o_dio1_irq
);

    logic       periph_rst_n;  // Internal peripheral reset
    logic       timer_wr;
    logic       soft_reset;
    data_t      timer_count;
    pps_count_t pps_count;

    // ==============================
    // Reset and timing
    // ==============================
    reset_hold reset_hold_i (
        .clk            (clk),
        .rst_reg_n      (rst_reg_n),
        .i_soft_reset   (soft_reset),
        .o_periph_rst_n (periph_rst_n)
    );

    time_base time_base_i (
        .clk           (clk),
        .rst_reg_n     (periph_rst_n),
        .i_timer_wr    (timer_wr),
        .i_wdata       (i_wdata),
        .o_timer_count (timer_count),
        .o_timer_irq   (o_timer_irq)
    );

    async_inputs async_inputs_i (
        .clk         (clk),
        .rst_reg_n   (periph_rst_n),
        .i_pps_pin   (i_ui_in[4]),  // 1PPS
        .i_dio1_pin  (i_ui_in[0]),  // Radio DIO1
        .o_pps_count (pps_count),
        .o_dio1_irq  (o_dio1_irq)
    );

    // ==============================
    // Bus registers
    // ==============================
    mmio_regs mmio_regs_i (
        .clk           (clk),
        .rst_reg_n     (periph_rst_n),
        .i_addr        (i_addr),
        .i_write_n     (i_write_n),
        .i_wdata       (i_wdata),
        .i_ui_in       (i_ui_in),
        .i_timer_count (timer_count),
        .i_pps_count   (pps_count),
        .o_rdata       (o_rdata),
        .o_uo_out      (o_uo_out),
        .o_timer_wr    (timer_wr),
        .o_soft_reset  (soft_reset)
    );

endmodule

/* source/mmio_regs.sv */
// Peripheral register file on the CPU data bus
// Reads are combinational from i_addr; writes land at the next edge
// No register has a read side effect
// Slots of removed peripherals read as all ones

`timescale 1ns/1ns
`include "soc_consts.svh"

module mmio_regs
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_reg_n,      // Peripheral reset
    input  addr_t      i_addr,
    input  wstrb_t     i_write_n,      // Active low strobes
    input  data_t      i_wdata,
    input  pins_t      i_ui_in,        // Input pins
    input  data_t      i_timer_count,
    input  pps_count_t i_pps_count,
    output data_t      o_rdata,
    output pins_t      o_uo_out,       // Output pins
    output logic       o_timer_wr,     // TIMER write strobe
    output logic       o_soft_reset    // Keyed SYS_INFO write
);

    peri_slot_e slot;          // Decoded peripheral
    logic       wr_cycle;      // Any write on the bus
    logic       gpio_out_wr;
    logic       gpio_sel_wr;
    pins_t      gpio_out;      // Value driven on selected pins
    pins_t      gpio_out_sel;  // 1 = pin is GPIO, 0 = idle level

    // ==============================
    // Address decode
    // ==============================
    always_comb begin
        if ({i_addr[27:7], i_addr[1:0]} == `PERI_BASE_MATCH) begin
            slot = peri_slot_e'(i_addr[6:2]);  // Gaps in the map fall to default below
        end else begin
            slot = PERI_NONE;
        end
    end

    assign wr_cycle = (i_write_n != 2'b11);

    // Write strobes
    assign gpio_out_wr  = wr_cycle && (slot == PERI_GPIO_OUT);
    assign gpio_sel_wr  = wr_cycle && (slot == PERI_GPIO_OUT_SEL);
    assign o_timer_wr   = wr_cycle && (slot == PERI_TIMER);
    assign o_soft_reset = wr_cycle && (slot == PERI_SYSINFO)
                          && (i_wdata[7:0] == `SOFT_RESET_KEY);  // Other bytes are ignored

    // ==============================
    // GPIO registers
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            gpio_out     <= '0;
            gpio_out_sel <= '0;  // All pins start on their idle level
        end else begin
            if (gpio_out_wr) begin
                gpio_out <= i_wdata[7:0];
            end
            if (gpio_sel_wr) begin
                gpio_out_sel <= i_wdata[7:0];
            end
        end
    end

    // Pin mux, per bit: GPIO value if selected, else idle level
    // 0 UART TX, 1 radio RESET, 2 SCL, 3 MOSI, 4 CS, 5 SCK, 6 SDA, 7 LED
    assign o_uo_out = (gpio_out_sel & gpio_out) | (~gpio_out_sel & `PIN_IDLE_LEVELS);

    // ==============================
    // Read data mux
    // ==============================
    always_comb begin
        case (slot)
            PERI_GPIO_OUT: begin
                o_rdata = {24'h0, o_uo_out};  // Actual pin levels, not the register
            end
            PERI_GPIO_IN: begin
                o_rdata = {24'h0, i_ui_in};
            end
            PERI_GPIO_OUT_SEL: begin
                o_rdata = {24'h0, gpio_out_sel};
            end
            PERI_TIMER: begin
                o_rdata = i_timer_count;
            end
            PERI_SYSINFO: begin
                o_rdata = {i_pps_count, `CHIP_ID, `CHIP_VERSION};
            end
            default: begin
                o_rdata = `READ_UNMAPPED;
            end
        endcase
    end

    // Timer load and soft reset come from different slots
    a_wr_exclusive : assert property (
        @(posedge clk) disable iff (!rst_reg_n)
        !(o_timer_wr && o_soft_reset)
    ) else $error("timer write and soft reset in the same cycle");

endmodule

/* source/reset_hold.sv */
// Peripheral reset generator
// The soft reset request must be a single-cycle pulse; a longer one restarts the hold
// Peripheral reset is registered, so it lags rst_reg_n by one cycle

`timescale 1ns/1ns
`include "soc_consts.svh"

module reset_hold (
    input  logic clk,
    input  logic rst_reg_n,      // External sync reset, active low
    input  logic i_soft_reset,   // Keyed SYS_INFO write
    output logic o_periph_rst_n  // Reset for every other module
);

    logic [5:0] hold_cnt;  // Cycles of soft reset still to hold

    // Load on request, then run down to zero
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            hold_cnt <= 6'd0;
        end else if (i_soft_reset) begin
            hold_cnt <= 6'(`RESET_HOLD_CYCLES);
        end else if (hold_cnt != 6'd0) begin
            hold_cnt <= hold_cnt - 6'd1;
        end
    end

    // Out of reset only when the pin is high and no hold is pending
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            o_periph_rst_n <= 1'b0;
        end else begin
            o_periph_rst_n <= (hold_cnt == 6'd0);  // One edge after the load it drops
        end
    end

    // Hold length is bounded by the configured value
    a_hold_bound : assert property (
        @(posedge clk) disable iff (!rst_reg_n)
        hold_cnt <= 6'(`RESET_HOLD_CYCLES)
    ) else $error("reset hold counter above limit");

endmodule

/* source/soc_consts.svh */
// Shared constants for the LoRa node peripheral block
// Assumes a 25 MHz clk, so one microsecond is 25 cycles
// Pin idle levels stand in for the UART, SPI and I2C functions not built here

`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// ==============================
// Timing
// ==============================
`define CLKS_PER_US        25             // 25 MHz / 25 = 1 MHz tick
`define RESET_HOLD_CYCLES  32             // Soft reset hold length in clk cycles

// ==============================
// Bus map and keys
// ==============================
`define PERI_BASE_MATCH    23'h400000     // Required value of {addr[27:7], addr[1:0]}
`define SOFT_RESET_KEY     8'hA5          // Low byte written to SYS_INFO
`define READ_UNMAPPED      32'hFFFF_FFFF  // Unmapped and removed slots

// ==============================
// Identification
// ==============================
`define CHIP_ID            8'h01
`define CHIP_VERSION       8'h10          // v1.0

// Idle levels, bit 7 down to bit 0:
// LED 0, SDA 1, SCK 0, CS 1, MOSI 0, SCL 1, radio RESET 1, UART TX 1
`define PIN_IDLE_LEVELS    8'h57

`endif

/* source/soc_pkg.sv */
// Types shared by the peripheral block and its testbench
// Slot numbers follow the full SoC map; missing slots read as all ones

package soc_pkg;

    typedef logic [27:0] addr_t;       // CPU data bus address
    typedef logic [31:0] data_t;       // Bus data, also the timer count
    typedef logic [1:0]  wstrb_t;      // Active low, anything but 2'b11 is a write
    typedef logic [7:0]  pins_t;       // One 8-bit pin group
    typedef logic [15:0] pps_count_t;  // Wrapping 1PPS edge count

    // Peripheral slot, taken from addr[6:2]
    typedef enum logic [4:0] {
        PERI_GPIO_OUT     = 5'd0,   // R/W output register, reads back the pins
        PERI_GPIO_IN      = 5'd1,   // R input pins
        PERI_GPIO_OUT_SEL = 5'd3,   // R/W pin function select
        PERI_TIMER        = 5'd12,  // R/W countdown timer
        PERI_SYSINFO      = 5'd15,  // R ID and PPS count, W soft reset key
        PERI_NONE         = 5'd31   // Address outside the peripheral base
    } peri_slot_e;

endpackage

/* source/time_base.sv */
// Microsecond tick and 32-bit countdown timer
// Tick phase restarts at every peripheral reset release
// Interrupt is a sticky level, cleared only by the next timer write
// CLKS_PER_US must be 2 or more

`timescale 1ns/1ns
`include "soc_consts.svh"

module time_base
    import soc_pkg::*;
#(
    parameter int CLKS_PER_US = `CLKS_PER_US
) (
    input  logic  clk,
    input  logic  rst_reg_n,     // Peripheral reset
    input  logic  i_timer_wr,    // One-cycle TIMER slot write
    input  data_t i_wdata,       // New count on a write
    output data_t o_timer_count,
    output logic  o_timer_irq
);

    localparam int DIV_W = $clog2(CLKS_PER_US);

    logic [DIV_W-1:0] div_cnt;  // Position within the microsecond
    logic             tick;     // One cycle in every CLKS_PER_US

    // ==============================
    // Microsecond divider
    // ==============================
    assign tick = (div_cnt == DIV_W'(CLKS_PER_US - 1));

    always_ff @(posedge clk) begin
        if (!rst_reg_n || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ==============================
    // Countdown timer
    // ==============================
    // A write wins over a tick in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            o_timer_count <= '0;
            o_timer_irq   <= 1'b0;
        end else if (i_timer_wr) begin
            o_timer_count <= i_wdata;
            o_timer_irq   <= 1'b0;  // Fresh count clears a pending interrupt
        end else if (tick && (o_timer_count != '0)) begin
            o_timer_count <= o_timer_count - 1'b1;
            if (o_timer_count == data_t'(1)) begin
                o_timer_irq <= 1'b1;  // Expiry, 1 -> 0
            end
        end
    end

    // Interrupt can only be raised by a tick, never by a write
    a_irq_on_tick : assert property (
        @(posedge clk) disable iff (!rst_reg_n)
        $rose(o_timer_irq) |-> $past(tick)
    ) else $error("timer interrupt rose outside a tick");

endmodule

/* verif/tb_lora_periph.sv */
// Random test of the LoRa node peripheral block against a behavioral model
// Inputs change on the falling clk edge, outputs are sampled before the next rising edge
// i_ui_in bits 0 and 4 are reserved for DIO1 and 1PPS and stay low outside the pin test

`timescale 1ns/1ns
`include "soc_consts.svh"

module tb_lora_periph
    import soc_pkg::*;
();

    localparam logic [22:0] base_match = `PERI_BASE_MATCH;

    logic   clk;
    logic   rst_reg_n;
    addr_t  i_addr;
    wstrb_t i_write_n;
    data_t  i_wdata;
    pins_t  i_ui_in;
    data_t  o_rdata;
    pins_t  o_uo_out;
    logic   o_timer_irq;
    logic   o_dio1_irq;

    integer     seed;
    int         errors;
    int         tests;
    int         test_mark;     // Error count at the start of the running test
    pins_t      exp_gpio_out;  // Model of the GPIO registers
    pins_t      exp_gpio_sel;
    pps_count_t exp_pps;       // Model of the PPS counter
    logic       dio_prev1;     // DIO1 pin value driven one cycle back
    logic       dio_prev2;     // and two cycles back

    lora_periph_top lora_periph_top_i (
        .clk         (clk),
        .rst_reg_n   (rst_reg_n),
        .i_addr      (i_addr),
        .i_write_n   (i_write_n),
        .i_wdata     (i_wdata),
        .i_ui_in     (i_ui_in),
        .o_rdata     (o_rdata),
        .o_uo_out    (o_uo_out),
        .o_timer_irq (o_timer_irq),
        .o_dio1_irq  (o_dio1_irq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;  // 20 ns period
        end
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic addr_t slot_addr(input logic [4:0] slot);
        slot_addr = {base_match[22:2], slot, base_match[1:0]};  // Word aligned in the base
    endfunction

    // Each pin shows its GPIO bit when selected, else the idle level of its function
    function automatic pins_t pin_levels(input pins_t out_val, input pins_t sel_val);
        pins_t idle;
        idle = `PIN_IDLE_LEVELS;
        for (int b = 0; b < 8; b++) begin
            if (sel_val[b])
                pin_levels[b] = out_val[b];
            else
                pin_levels[b] = idle[b];
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("failure at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name);
        $display("%s test done, %0d errors", name, errors - test_mark);
        tests++;
        test_mark = errors;
    endtask

    // One write cycle; the register has updated when this returns
    task automatic bus_write(input addr_t addr, input data_t data);
        @(negedge clk);
        i_addr    = addr;
        i_write_n = wstrb_t'($unsigned($random(seed)) % 3);  // Any strobe but 2'b11
        i_wdata   = data;
        @(negedge clk);
        i_write_n = 2'b11;
    endtask

    task automatic bus_read(input addr_t addr, output data_t data);
        @(negedge clk);
        i_addr    = addr;
        i_write_n = 2'b11;
        #1;
        data = o_rdata;  // Combinational, settled well before the rising edge
    endtask

    // One cycle of the pin test, checks DIO1 against the value from two cycles back
    task automatic drive_pin_cycle(input logic pps_level);
        @(negedge clk);
        if (o_dio1_irq !== dio_prev2)
            report_mismatch("o_dio1_irq", o_dio1_irq, dio_prev2);
        dio_prev2  = dio_prev1;
        dio_prev1  = 1'($random(seed));
        i_ui_in[0] = dio_prev1;
        i_ui_in[4] = pps_level;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        data_t  rdata;
        pins_t  out_val;
        pins_t  sel_val;
        pins_t  exp_pins;
        int     n;
        int     waited;
        int     pulses;
        logic   irq_seen;
        logic [7:0] key_byte;
        addr_t  bad_addr [5];

        seed      = 32'h4c5d;
        errors    = 0;
        tests     = 0;
        test_mark = 0;
        rst_reg_n = 1'b0;
        i_addr    = '0;
        i_write_n = 2'b11;  // Idle bus
        i_wdata   = '0;
        i_ui_in   = '0;
        exp_gpio_out = '0;
        exp_gpio_sel = '0;
        exp_pps      = '0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_reg_n = 1'b1;
        repeat (3) @(negedge clk);  // Peripheral reset follows one cycle later

        // Reset state
        if (o_uo_out !== pins_t'(`PIN_IDLE_LEVELS))
            report_mismatch("o_uo_out", o_uo_out, `PIN_IDLE_LEVELS);
        if (o_timer_irq !== 1'b0)
            report_mismatch("o_timer_irq", o_timer_irq, 1'b0);
        if (o_dio1_irq !== 1'b0)
            report_mismatch("o_dio1_irq", o_dio1_irq, 1'b0);
        bus_read(slot_addr(PERI_SYSINFO), rdata);
        if (rdata !== {16'h0, `CHIP_ID, `CHIP_VERSION})
            report_mismatch("sysinfo", rdata, {16'h0, `CHIP_ID, `CHIP_VERSION});
        finish_test("reset");

        // GPIO registers, pin mux and input readback
        for (int i = 0; i < 30; i++) begin
            out_val = pins_t'($random(seed));
            sel_val = pins_t'($random(seed));
            if (($random(seed) & 3) != 0) begin  // Sometimes keep the old value
                bus_write(slot_addr(PERI_GPIO_OUT), data_t'(out_val));
                exp_gpio_out = out_val;
            end
            if (($random(seed) & 3) != 0) begin
                bus_write(slot_addr(PERI_GPIO_OUT_SEL), data_t'(sel_val));
                exp_gpio_sel = sel_val;
            end
            exp_pins = pin_levels(exp_gpio_out, exp_gpio_sel);
            @(negedge clk);
            i_ui_in = pins_t'($random(seed)) & 8'hEE;  // DIO1 and PPS held low
            if (o_uo_out !== exp_pins)
                report_mismatch("o_uo_out", o_uo_out, exp_pins);
            bus_read(slot_addr(PERI_GPIO_OUT), rdata);  // Reads back the pin levels
            if (rdata !== {24'h0, exp_pins})
                report_mismatch("gpio_out", rdata, {24'h0, exp_pins});
            bus_read(slot_addr(PERI_GPIO_OUT_SEL), rdata);
            if (rdata !== {24'h0, exp_gpio_sel})
                report_mismatch("gpio_out_sel", rdata, {24'h0, exp_gpio_sel});
            bus_read(slot_addr(PERI_GPIO_IN), rdata);
            if (rdata !== {24'h0, i_ui_in})
                report_mismatch("gpio_in", rdata, {24'h0, i_ui_in});
        end
        finish_test("gpio");

        // Countdown timer, three random loads
        for (int round = 0; round < 3; round++) begin
            n = 1 + int'($unsigned($random(seed)) % 8);
            bus_write(slot_addr(PERI_TIMER), data_t'(n));
            if (o_timer_irq !== 1'b0)  // Load clears any earlier interrupt
                report_mismatch("o_timer_irq", o_timer_irq, 1'b0);
            waited   = 0;
            irq_seen = 1'b0;
            while (!irq_seen && waited < n * `CLKS_PER_US + 26) begin
                bus_read(slot_addr(PERI_TIMER), rdata);
                waited++;
                if (o_timer_irq === 1'b1) begin
                    irq_seen = 1'b1;
                    if (rdata !== '0)
                        report_mismatch("timer count", rdata, 32'h0);
                end else if (rdata == '0 || rdata > data_t'(n)) begin
                    report_failure($sformatf("timer count %0d outside 1..%0d, no irq", rdata, n));
                end
            end
            if (!irq_seen)
                report_failure($sformatf("timer irq missing %0d cycles after load", waited));
        end
        bus_write(slot_addr(PERI_TIMER), '0);
        if (o_timer_irq !== 1'b0)
            report_mismatch("o_timer_irq", o_timer_irq, 1'b0);
        finish_test("timer");

        // PPS pulses, 4 high and 6 low, with DIO1 toggling at random
        pulses    = 3 + int'($unsigned($random(seed)) % 8);
        dio_prev1 = i_ui_in[0];
        dio_prev2 = i_ui_in[0];
        for (int i = 0; i < pulses; i++) begin
            for (int j = 0; j < 10; j++) begin
                drive_pin_cycle(j < 4);
            end
        end
        exp_pps = exp_pps + pps_count_t'(pulses);
        drive_pin_cycle(1'b0);
        drive_pin_cycle(1'b0);
        @(negedge clk);
        i_ui_in[0] = 1'b0;
        bus_read(slot_addr(PERI_SYSINFO), rdata);
        if (rdata[31:16] !== exp_pps)
            report_mismatch("pps count", rdata[31:16], exp_pps);
        finish_test("input pins");

        // ==============================
        // Decode and soft reset
        // ==============================
        bad_addr[0] = slot_addr(5'd2);
        bad_addr[1] = slot_addr(5'd4);
        bad_addr[2] = slot_addr(5'd13);
        bad_addr[3] = slot_addr(PERI_SYSINFO) ^ 28'h800_0000;  // Outside the base
        bad_addr[4] = slot_addr(PERI_GPIO_IN) | 28'h1;         // Misaligned
        for (int i = 0; i < 5; i++) begin
            bus_read(bad_addr[i], rdata);
            if (rdata !== `READ_UNMAPPED)
                report_mismatch("unmapped read", rdata, `READ_UNMAPPED);
        end

        exp_gpio_out = pins_t'($random(seed)) | 8'h80;  // LED pin driven high, idle is low
        exp_gpio_sel = pins_t'($random(seed)) | 8'h81;  // Make a reset visible on the pins
        bus_write(slot_addr(PERI_GPIO_OUT), data_t'(exp_gpio_out));
        bus_write(slot_addr(PERI_GPIO_OUT_SEL), data_t'(exp_gpio_sel));

        key_byte = 8'($random(seed));
        if (key_byte == `SOFT_RESET_KEY)
            key_byte = key_byte ^ 8'h01;
        bus_write(slot_addr(PERI_SYSINFO), {24'($random(seed)), key_byte});
        repeat (40) @(negedge clk);
        if (o_uo_out !== pin_levels(exp_gpio_out, exp_gpio_sel))
            report_mismatch("o_uo_out", o_uo_out, pin_levels(exp_gpio_out, exp_gpio_sel));
        bus_read(slot_addr(PERI_SYSINFO), rdata);
        if (rdata[31:16] !== exp_pps)
            report_mismatch("pps count", rdata[31:16], exp_pps);

        // Keyed write clears GPIO and PPS state
        bus_write(slot_addr(PERI_SYSINFO), {24'($random(seed)), `SOFT_RESET_KEY});
        repeat (40) @(negedge clk);
        exp_gpio_out = '0;
        exp_gpio_sel = '0;
        exp_pps      = '0;
        if (o_uo_out !== pins_t'(`PIN_IDLE_LEVELS))
            report_mismatch("o_uo_out", o_uo_out, `PIN_IDLE_LEVELS);
        bus_read(slot_addr(PERI_GPIO_OUT_SEL), rdata);
        if (rdata !== 32'h0)
            report_mismatch("gpio_out_sel", rdata, 32'h0);
        bus_read(slot_addr(PERI_SYSINFO), rdata);
        if (rdata !== {16'h0, `CHIP_ID, `CHIP_VERSION})
            report_mismatch("sysinfo", rdata, {16'h0, `CHIP_ID, `CHIP_VERSION});

        // All pins on GPIO show the cleared output register
        exp_gpio_sel = 8'hFF;
        bus_write(slot_addr(PERI_GPIO_OUT_SEL), data_t'(exp_gpio_sel));
        if (o_uo_out !== exp_gpio_out)
            report_mismatch("o_uo_out", o_uo_out, exp_gpio_out);

        // Registers take writes again once the hold is over
        exp_gpio_out = pins_t'($random(seed)) | 8'h01;  // Nonzero, so the write shows
        bus_write(slot_addr(PERI_GPIO_OUT), data_t'(exp_gpio_out));
        if (o_uo_out !== exp_gpio_out)
            report_mismatch("o_uo_out", o_uo_out, exp_gpio_out);
        finish_test("decode and soft reset");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
